// ==== design/cache_pkg.sv ====
package cache_pkg;

	localparam int LINE_BITS   = 128;
	localparam int LINE_BYTES  = 16;
	localparam int NUM_SETS    = 4;
	localparam int NUM_WAYS    = 4;
	localparam int OFFSET_BITS = 4;
	localparam int INDEX_BITS  = 2;
	localparam int TAG_BITS    = 26;

	typedef logic [31:0]             addr_t;
	typedef logic [LINE_BITS-1:0]    line_t;
	typedef logic [LINE_BYTES-1:0]   byte_en_t;
	typedef logic [TAG_BITS-1:0]     tag_t;
	typedef logic [INDEX_BITS-1:0]   index_t;
	typedef logic [NUM_WAYS-1:0]     way_mask_t;

	// Root in bit 2, left pair in bit 1, right pair in bit 0
	typedef logic [2:0] plru_t;

	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		WRITEBACK,
		REFILL,
		RESPOND
	} ctrl_state_t;

	// Replace the enabled bytes of a line
	function automatic line_t merge_bytes(line_t old_line, line_t new_data, byte_en_t be);
		line_t merged;
		merged = old_line;
		for (int b = 0; b < LINE_BYTES; b++) begin
			if (be[b])
				merged[8*b +: 8] = new_data[8*b +: 8];
		end
		return merged;
	endfunction

endpackage

// ==== design/way_if.sv ====
`timescale 1ns/1ns

// Common command bus from the controller to all ways
interface way_cmd_if;
	cache_pkg::index_t    index;
	cache_pkg::tag_t      tag;
	cache_pkg::way_mask_t write_en;
	cache_pkg::way_mask_t fill_en;
	cache_pkg::byte_en_t  byte_en;
	cache_pkg::line_t     wdata;
	cache_pkg::line_t     fill_line;

	modport ctrl (output index, tag, write_en, fill_en, byte_en, wdata, fill_line);
	modport way (input index, tag, write_en, fill_en, byte_en, wdata, fill_line);
endinterface

// Merged lookup results, victim selected by the controller
interface way_result_if;
	logic                 any_hit;
	cache_pkg::way_mask_t hit_way;
	cache_pkg::line_t     hit_line;
	cache_pkg::way_mask_t valid_mask;
	cache_pkg::way_mask_t victim_way;
	logic                 victim_dirty;
	cache_pkg::tag_t      victim_tag;
	cache_pkg::line_t     victim_line;

	modport merge (output any_hit, hit_way, hit_line, valid_mask, victim_dirty, victim_tag,
		victim_line, input victim_way);
	modport ctrl (input any_hit, hit_way, hit_line, valid_mask, victim_dirty, victim_tag,
		victim_line, output victim_way);
endinterface

// ==== design/cache_way.sv ====
`timescale 1ns/1ns

module cache_way #(
	parameter int WAY_ID = 0
) (
	input  logic             clk,
	input  logic             reset,
	way_cmd_if.way           cmd,
	output logic             hit,
	output logic             valid,
	output logic             dirty,
	output cache_pkg::tag_t  tag,
	output cache_pkg::line_t line
);

	cache_pkg::tag_t               tags  [cache_pkg::NUM_SETS];
	cache_pkg::line_t              lines [cache_pkg::NUM_SETS];
	logic [cache_pkg::NUM_SETS-1:0] valid_bits;
	logic [cache_pkg::NUM_SETS-1:0] dirty_bits;
	logic                          write_sel;
	logic                          fill_sel;

	assign write_sel = cmd.write_en[WAY_ID];
	assign fill_sel  = cmd.fill_en[WAY_ID];

	// Entry at the commanded set
	assign valid = valid_bits[cmd.index];
	assign dirty = dirty_bits[cmd.index];
	assign tag   = tags[cmd.index];
	assign line  = lines[cmd.index];
	assign hit   = valid && (tags[cmd.index] == cmd.tag);

	always_ff @(posedge clk) begin
		if (fill_sel) begin
			lines[cmd.index] <= cmd.fill_line;
			tags[cmd.index]  <= cmd.tag;
		end else if (write_sel) begin
			lines[cmd.index] <= cache_pkg::merge_bytes(lines[cmd.index], cmd.wdata,
				cmd.byte_en);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end else if (fill_sel) begin
			valid_bits[cmd.index] <= 1'b1;
			dirty_bits[cmd.index] <= 1'b0;
		end else if (write_sel) begin
			dirty_bits[cmd.index] <= 1'b1;
		end
	end

endmodule

// ==== design/way_merge.sv ====
`timescale 1ns/1ns

module way_merge (
	input  cache_pkg::way_mask_t                           way_hit,
	input  cache_pkg::way_mask_t                           way_valid,
	input  cache_pkg::way_mask_t                           way_dirty,
	input  cache_pkg::tag_t  [cache_pkg::NUM_WAYS-1:0]     way_tag,
	input  cache_pkg::line_t [cache_pkg::NUM_WAYS-1:0]     way_line,
	way_result_if.merge                                    res
);

	cache_pkg::line_t hit_line;
	cache_pkg::line_t victim_line;
	cache_pkg::tag_t  victim_tag;

	assign res.any_hit      = |way_hit;
	assign res.hit_way      = way_hit;
	assign res.valid_mask   = way_valid;
	assign res.victim_dirty = |(way_dirty & res.victim_way);

	// One-hot muxes, at most one hit per set
	always_comb begin
		hit_line    = '0;
		victim_line = '0;
		victim_tag  = '0;
		for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
			if (way_hit[w])
				hit_line = hit_line | way_line[w];
			if (res.victim_way[w]) begin
				victim_line = victim_line | way_line[w];
				victim_tag  = victim_tag | way_tag[w];
			end
		end
	end

	assign res.hit_line    = hit_line;
	assign res.victim_line = victim_line;
	assign res.victim_tag  = victim_tag;

endmodule

// ==== design/cache_controller.sv ====
`timescale 1ns/1ns

module cache_controller (
	input  logic                clk,
	input  logic                reset,
	input  logic                req,
	input  logic                write,
	input  cache_pkg::addr_t    addr,
	input  cache_pkg::byte_en_t byte_en,
	input  cache_pkg::line_t    wdata,
	output logic                ready,
	output logic                resp_valid,
	output logic                hit,
	output cache_pkg::line_t    rdata,
	output logic                mem_write_req,
	output cache_pkg::addr_t    mem_write_addr,
	output cache_pkg::line_t    mem_write_data,
	input  logic                mem_write_ack,
	output logic                mem_read_req,
	output cache_pkg::addr_t    mem_read_addr,
	input  cache_pkg::line_t    mem_read_data,
	input  logic                mem_read_ack,
	way_cmd_if.ctrl             cmd,
	way_result_if.ctrl          res
);

	cache_pkg::ctrl_state_t state;
	cache_pkg::addr_t       req_addr;
	logic                   req_write;
	cache_pkg::byte_en_t    req_byte_en;
	cache_pkg::line_t       req_wdata;
	cache_pkg::tag_t        req_tag;
	cache_pkg::index_t      req_index;
	logic                   missed;
	logic                   accept;
	logic                   victim_needs_wb;
	cache_pkg::plru_t       plru [cache_pkg::NUM_SETS];
	cache_pkg::plru_t       plru_cur;
	cache_pkg::plru_t       plru_next;
	cache_pkg::way_mask_t   victim_choice;
	cache_pkg::way_mask_t   victim_q;

	// Address split, offset is not needed since whole lines move
	assign req_tag   = req_addr[31 -: cache_pkg::TAG_BITS];
	assign req_index = req_addr[cache_pkg::OFFSET_BITS +: cache_pkg::INDEX_BITS];

	assign ready      = (state == cache_pkg::IDLE) || (state == cache_pkg::RESPOND);
	assign resp_valid = (state == cache_pkg::RESPOND);
	assign accept     = req && ready;
	assign plru_cur   = plru[req_index];

	assign cmd.index     = req_index;
	assign cmd.tag       = req_tag;
	assign cmd.byte_en   = req_byte_en;
	assign cmd.wdata     = req_wdata;
	assign cmd.fill_line = mem_read_data;
	assign cmd.write_en  = (state == cache_pkg::LOOKUP && res.any_hit && req_write) ?
		res.hit_way : '0;
	assign cmd.fill_en   = (state == cache_pkg::REFILL && mem_read_ack) ? victim_q : '0;

	// Live choice during lookup, recorded victim afterwards
	assign res.victim_way  = (state == cache_pkg::LOOKUP) ? victim_choice : victim_q;
	assign victim_needs_wb = res.victim_dirty && |(res.valid_mask & victim_choice);

	// Lowest invalid way first, else walk the tree
	always_comb begin
		victim_choice = '0;
		if (res.valid_mask != '1) begin
			for (int w = cache_pkg::NUM_WAYS - 1; w >= 0; w--) begin
				if (!res.valid_mask[w]) begin
					victim_choice    = '0;
					victim_choice[w] = 1'b1;
				end
			end
		end else if (!plru_cur[2]) begin
			victim_choice = plru_cur[1] ? 4'b0010 : 4'b0001;
		end else begin
			victim_choice = plru_cur[0] ? 4'b1000 : 4'b0100;
		end
	end

	// Point the tree away from the way just used
	always_comb begin
		case (res.hit_way)
			4'b0001: plru_next = {1'b1, 1'b1, plru_cur[0]};
			4'b0010: plru_next = {1'b1, 1'b0, plru_cur[0]};
			4'b0100: plru_next = {1'b0, plru_cur[1], 1'b1};
			4'b1000: plru_next = {1'b0, plru_cur[1], 1'b0};
			default: plru_next = plru_cur;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state         <= cache_pkg::IDLE;
			missed        <= 1'b0;
			hit           <= 1'b0;
			mem_write_req <= 1'b0;
			mem_read_req  <= 1'b0;
			for (int s = 0; s < cache_pkg::NUM_SETS; s++)
				plru[s] <= '0;
		end else begin
			case (state)
				cache_pkg::IDLE, cache_pkg::RESPOND: begin
					if (accept) begin
						state  <= cache_pkg::LOOKUP;
						missed <= 1'b0;
					end else begin
						state <= cache_pkg::IDLE;
					end
				end
				cache_pkg::LOOKUP: begin
					if (res.any_hit) begin
						state           <= cache_pkg::RESPOND;
						hit             <= !missed;
						plru[req_index] <= plru_next;
					end else if (victim_needs_wb) begin
						missed        <= 1'b1;
						mem_write_req <= 1'b1;
						state         <= cache_pkg::WRITEBACK;
					end else begin
						missed       <= 1'b1;
						mem_read_req <= 1'b1;
						state        <= cache_pkg::REFILL;
					end
				end
				cache_pkg::WRITEBACK: begin
					if (mem_write_ack) begin
						mem_write_req <= 1'b0;
						mem_read_req  <= 1'b1;
						state         <= cache_pkg::REFILL;
					end
				end
				cache_pkg::REFILL: begin
					// Fill strobe fires on this same edge
					if (mem_read_ack) begin
						mem_read_req <= 1'b0;
						state        <= cache_pkg::LOOKUP;
					end
				end
				default: state <= cache_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			req_addr    <= addr;
			req_write   <= write;
			req_byte_en <= byte_en;
			req_wdata   <= wdata;
		end
		if (state == cache_pkg::LOOKUP) begin
			if (res.any_hit) begin
				rdata <= cache_pkg::merge_bytes(res.hit_line, req_wdata,
					req_write ? req_byte_en : '0);
			end else begin
				victim_q       <= victim_choice;
				mem_write_addr <= {res.victim_tag, req_index, {cache_pkg::OFFSET_BITS{1'b0}}};
				mem_write_data <= res.victim_line;
				mem_read_addr  <= {req_tag, req_index, {cache_pkg::OFFSET_BITS{1'b0}}};
			end
		end
	end

endmodule

// ==== design/set_assoc_cache.sv ====
`timescale 1ns/1ns

module set_assoc_cache (
	input  logic                clk,
	input  logic                reset,
	input  logic                req,
	input  logic                write,
	input  cache_pkg::addr_t    addr,
	input  cache_pkg::byte_en_t byte_en,
	input  cache_pkg::line_t    wdata,
	output logic                ready,
	output logic                resp_valid,
	output logic                hit,
	output cache_pkg::line_t    rdata,
	output logic                mem_write_req,
	output cache_pkg::addr_t    mem_write_addr,
	output cache_pkg::line_t    mem_write_data,
	input  logic                mem_write_ack,
	output logic                mem_read_req,
	output cache_pkg::addr_t    mem_read_addr,
	input  cache_pkg::line_t    mem_read_data,
	input  logic                mem_read_ack
);

	way_cmd_if    cmd ();
	way_result_if res ();

	cache_pkg::way_mask_t                           way_hit;
	cache_pkg::way_mask_t                           way_valid;
	cache_pkg::way_mask_t                           way_dirty;
	cache_pkg::tag_t  [cache_pkg::NUM_WAYS-1:0]     way_tag;
	cache_pkg::line_t [cache_pkg::NUM_WAYS-1:0]     way_line;

	cache_controller u_ctrl (
		.clk            (clk),
		.reset          (reset),
		.req            (req),
		.write          (write),
		.addr           (addr),
		.byte_en        (byte_en),
		.wdata          (wdata),
		.ready          (ready),
		.resp_valid     (resp_valid),
		.hit            (hit),
		.rdata          (rdata),
		.mem_write_req  (mem_write_req),
		.mem_write_addr (mem_write_addr),
		.mem_write_data (mem_write_data),
		.mem_write_ack  (mem_write_ack),
		.mem_read_req   (mem_read_req),
		.mem_read_addr  (mem_read_addr),
		.mem_read_data  (mem_read_data),
		.mem_read_ack   (mem_read_ack),
		.cmd            (cmd),
		.res            (res)
	);

	for (genvar w = 0; w < cache_pkg::NUM_WAYS; w++) begin : g_way
		cache_way #(
			.WAY_ID (w)
		) u_way (
			.clk   (clk),
			.reset (reset),
			.cmd   (cmd),
			.hit   (way_hit[w]),
			.valid (way_valid[w]),
			.dirty (way_dirty[w]),
			.tag   (way_tag[w]),
			.line  (way_line[w])
		);
	end

	way_merge u_merge (
		.way_hit   (way_hit),
		.way_valid (way_valid),
		.way_dirty (way_dirty),
		.way_tag   (way_tag),
		.way_line  (way_line),
		.res       (res)
	);

endmodule

// ==== testbench/cache_checker.sv ====
`timescale 1ns/1ns

module cache_checker (
	input logic             clk,
	input logic             reset,
	input logic             ready,
	input logic             resp_valid,
	input logic             hit,
	input cache_pkg::line_t rdata,
	input logic             mem_write_req,
	input cache_pkg::addr_t mem_write_addr,
	input cache_pkg::line_t mem_write_data,
	input logic             mem_write_ack,
	input logic             mem_read_req,
	input cache_pkg::addr_t mem_read_addr,
	input logic             mem_read_ack
);

	int               pass_count = 0;
	int               fail_count = 0;
	logic             timed_out  = 1'b0;
	int               wb_count   = 0;
	int               rd_count   = 0;
	logic             wb_late    = 1'b0;
	cache_pkg::addr_t wb_addr;
	cache_pkg::line_t wb_data;
	cache_pkg::addr_t rd_addr;

	// What the client last saw in each line
	cache_pkg::line_t shadow [cache_pkg::addr_t];

	// A transfer completes while request and acknowledge are both high
	always @(negedge clk) begin
		if (!reset && mem_write_req && mem_write_ack) begin
			wb_count++;
			wb_addr = mem_write_addr;
			wb_data = mem_write_data;
			// Refill of this miss must still be pending
			wb_late = (rd_count != 0);
		end
		if (!reset && mem_read_req && mem_read_ack) begin
			rd_count++;
			rd_addr = mem_read_addr;
		end
	end

	function automatic cache_pkg::line_t initial_line(cache_pkg::addr_t a);
		cache_pkg::line_t l;
		for (int w = 0; w < 4; w++)
			l[32*w +: 32] = a + 32'(4 * w);
		return l;
	endfunction

	function automatic cache_pkg::line_t apply_write(cache_pkg::line_t old_line,
		cache_pkg::line_t wd, cache_pkg::byte_en_t be);
		cache_pkg::line_t mask;
		for (int b = 0; b < 16; b++)
			mask[8*b +: 8] = {8{be[b]}};
		return (old_line & ~mask) | (wd & mask);
	endfunction

	task automatic compare_value(input string name, input logic [127:0] got,
		input logic [127:0] exp, inout int errors);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic report_test(input int test_num, input int errors);
		if (errors == 0) begin
			pass_count++;
			$display("Test %0d passed", test_num);
		end else begin
			fail_count++;
			$display("Test %0d failed with %0d errors", test_num, errors);
		end
	endtask

	task automatic check_reset_state();
		int errors;
		errors = 0;
		@(negedge clk);
		compare_value("ready", ready, 1, errors);
		compare_value("resp_valid", resp_valid, 0, errors);
		compare_value("hit", hit, 0, errors);
		compare_value("mem_read_req", mem_read_req, 0, errors);
		compare_value("mem_write_req", mem_write_req, 0, errors);
		report_test(0, errors);
	endtask

	task automatic check_response(input int test_num, input logic wr, input cache_pkg::addr_t a,
		input cache_pkg::byte_en_t be, input cache_pkg::line_t wd,
		input cache_pkg::line_t exp_rdata, input logic exp_hit, input logic exp_wb,
		input cache_pkg::addr_t exp_wb_addr);
		int               errors;
		int               waited;
		cache_pkg::addr_t line_addr;
		cache_pkg::line_t predicted;
		errors    = 0;
		waited    = 0;
		wb_count  = 0;
		rd_count  = 0;
		wb_late   = 1'b0;
		line_addr = {a[31:4], 4'b0000};
		@(negedge clk);
		while (!resp_valid && waited < 100) begin
			@(negedge clk);
			waited++;
		end
		if (!resp_valid) begin
			$display("Test %0d: timed out waiting for resp_valid", test_num);
			timed_out = 1'b1;
			fail_count++;
		end else begin
			compare_value("rdata", rdata, exp_rdata, errors);
			compare_value("hit", hit, exp_hit, errors);
			compare_value("ready", ready, 1, errors);
			// Hit answers one cycle after acceptance
			if (exp_hit && waited != 1) begin
				$display("Test %0d: hit answered after %0d cycles instead of 1", test_num,
					waited);
				errors++;
			end
			if (wb_count != (exp_wb ? 1 : 0)) begin
				$display("Test %0d: expected %0d write-backs but saw %0d", test_num,
					exp_wb ? 1 : 0, wb_count);
				errors++;
			end else if (exp_wb) begin
				predicted = shadow.exists(exp_wb_addr) ? shadow[exp_wb_addr] :
					initial_line(exp_wb_addr);
				compare_value("mem_write_addr", wb_addr, exp_wb_addr, errors);
				compare_value("mem_write_data", wb_data, predicted, errors);
				if (wb_late) begin
					$display("Test %0d: write-back came after the refill", test_num);
					errors++;
				end
			end
			// Refill expected only on a miss
			if (rd_count != (exp_hit ? 0 : 1)) begin
				$display("Test %0d: expected %0d refills but saw %0d", test_num,
					exp_hit ? 0 : 1, rd_count);
				errors++;
			end else if (!exp_hit) begin
				compare_value("mem_read_addr", rd_addr, line_addr, errors);
			end
			if (wr) begin
				predicted = shadow.exists(line_addr) ? shadow[line_addr] : initial_line(line_addr);
				shadow[line_addr] = apply_write(predicted, wd, be);
			end
			report_test(test_num, errors);
		end
	endtask

endmodule

// ==== testbench/cache_tb.sv ====
`timescale 1ns/1ns

module cache_tb;

	logic                clk;
	logic                reset;
	logic                req;
	logic                write;
	cache_pkg::addr_t    addr;
	cache_pkg::byte_en_t byte_en;
	cache_pkg::line_t    wdata;
	logic                ready;
	logic                resp_valid;
	logic                hit;
	cache_pkg::line_t    rdata;
	logic                mem_write_req;
	cache_pkg::addr_t    mem_write_addr;
	cache_pkg::line_t    mem_write_data;
	logic                mem_write_ack;
	logic                mem_read_req;
	cache_pkg::addr_t    mem_read_addr;
	cache_pkg::line_t    mem_read_data;
	logic                mem_read_ack;

	// Backing store, only lines that were written back
	cache_pkg::line_t    mem [cache_pkg::addr_t];
	int                  ack_delay;
	int                  rand_init;
	logic                aborted;
	int                  tests_run;

	set_assoc_cache DUT (.*);

	cache_checker u_check (.*);

	always #2 clk = ~clk;

	// Every 32-bit word starts out holding its own byte address
	function automatic cache_pkg::line_t power_up_line(cache_pkg::addr_t a);
		cache_pkg::line_t l;
		for (int w = 0; w < 4; w++)
			l[32*w +: 32] = a + 32'(4 * w);
		return l;
	endfunction

	// Slow memory, acknowledges after 0 to 5 extra cycles
	always begin
		@(posedge clk);
		#1;
		mem_write_ack = 1'b0;
		mem_read_ack  = 1'b0;
		if (!reset && mem_write_req) begin
			ack_delay = $urandom_range(5, 0);
			repeat (ack_delay) begin
				@(posedge clk);
				#1;
			end
			mem[mem_write_addr] = mem_write_data;
			mem_write_ack = 1'b1;
		end else if (!reset && mem_read_req) begin
			ack_delay = $urandom_range(5, 0);
			repeat (ack_delay) begin
				@(posedge clk);
				#1;
			end
			mem_read_data = mem.exists(mem_read_addr) ? mem[mem_read_addr] :
				power_up_line(mem_read_addr);
			mem_read_ack = 1'b1;
		end
	end

	task automatic send_request(input logic wr, input cache_pkg::addr_t a,
		input cache_pkg::byte_en_t be, input cache_pkg::line_t wd, output logic accepted);
		int waited;
		waited = 0;
		@(posedge clk);
		#1;
		while (!ready && waited < 200) begin
			@(posedge clk);
			#1;
			waited++;
		end
		accepted = ready;
		if (ready) begin
			req     = 1'b1;
			write   = wr;
			addr    = a;
			byte_en = be;
			wdata   = wd;
			@(posedge clk);
			#1;
			req = 1'b0;
		end
	endtask

	initial begin
		int                  fd;
		int                  fields;
		int                  test_num;
		int                  exp_hit;
		string               op_str;
		string               wb_str;
		cache_pkg::addr_t    a;
		cache_pkg::byte_en_t be;
		cache_pkg::line_t    wd;
		cache_pkg::line_t    exp_rdata;
		logic [8*160-1:0]    text;
		logic                accepted;

		rand_init     = $urandom(32'hceee_0fb7);
		clk           = 1'b0;
		reset         = 1'b1;
		req           = 1'b0;
		write         = 1'b0;
		addr          = '0;
		byte_en       = '0;
		wdata         = '0;
		mem_write_ack = 1'b0;
		mem_read_ack  = 1'b0;
		mem_read_data = '0;
		aborted       = 1'b0;
		tests_run     = 0;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		u_check.check_reset_state();

		fd = $fopen("testbench/cache_trace.txt", "r");
		if (fd == 0) begin
			$display("Could not open the trace file");
			aborted = 1'b1;
		end
		while (!aborted && !$feof(fd)) begin
			text = '0;
			fields = $fgets(text, fd);
			fields = $sscanf(text, "%d %s %h %h %h %h %d %s", test_num, op_str, a, be, wd,
				exp_rdata, exp_hit, wb_str);
			// Comment and blank lines do not parse into eight fields
			if (fields == 8) begin
				tests_run++;
				send_request(op_str == "W", a, be, wd, accepted);
				if (!accepted) begin
					$display("Test %0d: timed out waiting for ready", test_num);
					aborted = 1'b1;
				end else begin
					u_check.check_response(test_num, op_str == "W", a, be, wd, exp_rdata,
						exp_hit != 0, wb_str != "-", wb_str.atohex());
					if (u_check.timed_out)
						aborted = 1'b1;
				end
			end
		end
		if (fd != 0)
			$fclose(fd);

		$display("Totals: %0d passed, %0d failed", u_check.pass_count, u_check.fail_count);
		if (!aborted && tests_run > 0 && u_check.fail_count == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== flist.f ====
design/cache_pkg.sv
design/way_if.sv
design/cache_way.sv
design/way_merge.sv
design/cache_controller.sv
design/set_assoc_cache.sv
testbench/cache_checker.sv
testbench/cache_tb.sv

// ==== Bender.yml ====
package:
  name: set_assoc_cache

sources:
  - files:
      - design/cache_pkg.sv
      - design/way_if.sv
      - design/cache_way.sv
      - design/way_merge.sv
      - design/cache_controller.sv
      - design/set_assoc_cache.sv
  - target: test
    files:
      - testbench/cache_checker.sv
      - testbench/cache_tb.sv

// ==== testbench/cache_trace.txt ====
# test op addr byte_en wdata expected_rdata expected_hit writeback_addr
# hit is 1 only when the first lookup hits, writeback is a line address or - for none
1 R 00000008 0000 00000000000000000000000000000000 0000000C000000080000000400000000 0 -
2 R 00000000 0000 00000000000000000000000000000000 0000000C000000080000000400000000 1 -
3 W 00000004 0F0C 11111111222222223333333344444444 0000000C222222220000000444440000 1 -
4 R 00000000 0000 00000000000000000000000000000000 0000000C222222220000000444440000 1 -
5 W 00000044 F000 55555555666666667777777788888888 55555555000000480000004400000040 0 -
6 R 00000080 0000 00000000000000000000000000000000 0000008C000000880000008400000080 0 -
7 R 000000C0 0000 00000000000000000000000000000000 000000CC000000C8000000C4000000C0 0 -
8 R 00000100 0000 00000000000000000000000000000000 0000010C000001080000010400000100 0 00000000
9 R 00000140 0000 00000000000000000000000000000000 0000014C000001480000014400000140 0 -
10 R 00000000 0000 00000000000000000000000000000000 0000000C222222220000000444440000 0 00000040
11 R 00000040 0000 00000000000000000000000000000000 55555555000000480000004400000040 0 -
12 R 0000010C 0000 00000000000000000000000000000000 0000010C000001080000010400000100 1 -
13 R 00000030 0000 00000000000000000000000000000000 0000003C000000380000003400000030 0 -
14 W 00000034 FFFF 0123456789ABCDEFFEDCBA9876543210 0123456789ABCDEFFEDCBA9876543210 1 -
15 R 00000030 0000 00000000000000000000000000000000 0123456789ABCDEFFEDCBA9876543210 1 -
16 R 00000010 0000 00000000000000000000000000000000 0000001C000000180000001400000010 0 -
